// File: logic/bp_branch_counters.sv
module bp_branch_counters
  (input  logic                               clk_i
   , input  logic                             reset_i

   , input  logic                             commit_v_i
   , input  logic                             attaboy_v_i
   , input  logic                             redirect_v_i
   , input  bp_prof_pkg::bp_branch_metadata_s metadata_i

   , input  logic                             program_finish_i

   , output bp_prof_pkg::bp_branch_stats_s    stats_o
   , output logic                             report_v_o
   );

  bp_prof_pkg::bp_branch_stats_s stats_r;

  logic cmd_v;
  logic program_finish_r;
  logic report_r;

  // Either resolved command carries a valid branch class
  assign cmd_v = attaboy_v_i | redirect_v_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      stats_r <= '0;
    end
    else
    begin
      stats_r.instr_cnt    <= bp_prof_pkg::stat_inc(stats_r.instr_cnt, commit_v_i);
      stats_r.attaboy_cnt  <= bp_prof_pkg::stat_inc(stats_r.attaboy_cnt, attaboy_v_i);
      stats_r.redirect_cnt <= bp_prof_pkg::stat_inc(stats_r.redirect_cnt, redirect_v_i);

      stats_r.br_cnt   <= bp_prof_pkg::stat_inc(stats_r.br_cnt, cmd_v & metadata_i.is_br);
      stats_r.jal_cnt  <= bp_prof_pkg::stat_inc(stats_r.jal_cnt, cmd_v & metadata_i.is_jal);
      stats_r.jalr_cnt <= bp_prof_pkg::stat_inc(stats_r.jalr_cnt, cmd_v & metadata_i.is_jalr);

      // Hits are only known on a confirmed prediction
      stats_r.btb_hit_cnt <= bp_prof_pkg::stat_inc(stats_r.btb_hit_cnt,
                                                   attaboy_v_i & metadata_i.src_btb);
      stats_r.ras_hit_cnt <= bp_prof_pkg::stat_inc(stats_r.ras_hit_cnt,
                                                   attaboy_v_i & metadata_i.src_ret);
      stats_r.bht_hit_cnt <= bp_prof_pkg::stat_inc(stats_r.bht_hit_cnt,
                                                   attaboy_v_i & metadata_i.is_br);
    end
  end

  // A finish seen high right out of reset still counts as a rising edge
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      program_finish_r <= 1'b0;
      report_r         <= 1'b0;
    end
    else
    begin
      program_finish_r <= program_finish_i;
      report_r         <= program_finish_i & ~program_finish_r;
    end
  end

  assign stats_o    = stats_r;
  assign report_v_o = report_r;   // One cycle after the edge

endmodule

// File: logic/bp_branch_histo_table.sv
module bp_branch_histo_table
  (input  logic                                         clk_i
   , input  logic                                       reset_i

   , input  logic                                       attaboy_v_i
   , input  logic                                       redirect_v_i
   , input  logic [bp_prof_pkg::VADDR_WIDTH-1:0]        vaddr_i

   , input  logic [bp_prof_pkg::HISTO_IDX_WIDTH-1:0]    histo_idx_i
   , output bp_prof_pkg::bp_histo_entry_s               histo_entry_o
   , output logic [bp_prof_pkg::STAT_WIDTH-1:0]         histo_overflow_o
   );

  bp_prof_pkg::bp_histo_entry_s table_r [bp_prof_pkg::HISTO_ENTRIES];
  logic [bp_prof_pkg::STAT_WIDTH-1:0] overflow_r;

  logic                                      cmd_v;
  logic [bp_prof_pkg::HISTO_ENTRIES-1:0]     hit_vec;
  logic [bp_prof_pkg::HISTO_ENTRIES-1:0]     free_vec;
  logic                                      hit_v;
  logic                                      free_v;
  logic [bp_prof_pkg::HISTO_IDX_WIDTH-1:0]   hit_idx;
  logic [bp_prof_pkg::HISTO_IDX_WIDTH-1:0]   free_idx;

  assign cmd_v = attaboy_v_i | redirect_v_i;

  // Parallel compare against every row
  always_comb
  begin
    for (int i = 0; i < bp_prof_pkg::HISTO_ENTRIES; i++)
    begin
      hit_vec[i]  = table_r[i].valid & (table_r[i].vaddr == vaddr_i);
      free_vec[i] = ~table_r[i].valid;
    end
  end

  assign hit_v  = |hit_vec;
  assign free_v = |free_vec;

  // Scan from the top so the lowest set row wins
  always_comb
  begin
    hit_idx  = '0;
    free_idx = '0;
    for (int i = bp_prof_pkg::HISTO_ENTRIES - 1; i >= 0; i--)
    begin
      if (hit_vec[i])
      begin
        hit_idx = bp_prof_pkg::HISTO_IDX_WIDTH'(i);
      end
      if (free_vec[i])
      begin
        free_idx = bp_prof_pkg::HISTO_IDX_WIDTH'(i);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < bp_prof_pkg::HISTO_ENTRIES; i++)
      begin
        table_r[i] <= '0;
      end
      overflow_r <= '0;
    end
    else if (cmd_v)
    begin
      if (hit_v)
      begin
        table_r[hit_idx].occ_cnt  <= bp_prof_pkg::cnt_sat_inc(table_r[hit_idx].occ_cnt, 1'b1);
        table_r[hit_idx].miss_cnt <= bp_prof_pkg::cnt_sat_inc(table_r[hit_idx].miss_cnt,
                                                              redirect_v_i);
      end
      else if (free_v)
      begin
        table_r[free_idx].valid    <= 1'b1;
        table_r[free_idx].vaddr    <= vaddr_i;
        table_r[free_idx].occ_cnt  <= bp_prof_pkg::HISTO_CNT_WIDTH'(1);
        table_r[free_idx].miss_cnt <= bp_prof_pkg::HISTO_CNT_WIDTH'(redirect_v_i);
      end
      else
      begin
        overflow_r <= bp_prof_pkg::stat_inc(overflow_r, 1'b1);   // Table full, address lost
      end
    end
  end

  assign histo_entry_o    = table_r[histo_idx_i];
  assign histo_overflow_o = overflow_r;

endmodule

// File: logic/bp_branch_profiler.sv
module bp_branch_profiler
  (input  logic                                        clk_i
   , input  logic                                      reset_i

   , input  bp_prof_pkg::bp_fe_cmd_s                   fe_cmd_i
   , input  logic                                      fe_cmd_yumi_i
   , input  logic                                      commit_v_i
   , input  logic                                      program_finish_i
   , input  logic [bp_prof_pkg::HISTO_IDX_WIDTH-1:0]   histo_idx_i

   , output bp_prof_pkg::bp_branch_stats_s             stats_o
   , output bp_prof_pkg::bp_histo_entry_s              histo_entry_o
   , output logic [bp_prof_pkg::STAT_WIDTH-1:0]        histo_overflow_o
   , output logic                                      report_v_o
   );

  logic                                  attaboy_v;
  logic                                  redirect_v;
  bp_prof_pkg::bp_branch_metadata_s      metadata;
  logic [bp_prof_pkg::VADDR_WIDTH-1:0]   vaddr;

  bp_fe_cmd_decoder bp_fe_cmd_decoder_i
    (.fe_cmd_i(fe_cmd_i)
     ,.fe_cmd_yumi_i(fe_cmd_yumi_i)
     ,.attaboy_v_o(attaboy_v)
     ,.redirect_v_o(redirect_v)
     ,.metadata_o(metadata)
     ,.vaddr_o(vaddr)
     );

  bp_branch_counters bp_branch_counters_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.commit_v_i(commit_v_i)
     ,.attaboy_v_i(attaboy_v)
     ,.redirect_v_i(redirect_v)
     ,.metadata_i(metadata)
     ,.program_finish_i(program_finish_i)
     ,.stats_o(stats_o)
     ,.report_v_o(report_v_o)
     );

  bp_branch_histo_table bp_branch_histo_table_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.attaboy_v_i(attaboy_v)
     ,.redirect_v_i(redirect_v)
     ,.vaddr_i(vaddr)
     ,.histo_idx_i(histo_idx_i)
     ,.histo_entry_o(histo_entry_o)
     ,.histo_overflow_o(histo_overflow_o)
     );

endmodule

// File: logic/bp_fe_cmd_decoder.sv
module bp_fe_cmd_decoder
  (input  bp_prof_pkg::bp_fe_cmd_s               fe_cmd_i
   , input  logic                                fe_cmd_yumi_i

   , output logic                                attaboy_v_o
   , output logic                                redirect_v_o
   , output bp_prof_pkg::bp_branch_metadata_s    metadata_o
   , output logic [bp_prof_pkg::VADDR_WIDTH-1:0] vaddr_o
   );

  logic is_redirect_op;
  logic is_attaboy_op;

  assign is_redirect_op = (fe_cmd_i.opcode == bp_prof_pkg::e_op_pc_redirection);
  assign is_attaboy_op  = (fe_cmd_i.opcode == bp_prof_pkg::e_op_attaboy);

  // Only a command the front end actually takes counts
  assign redirect_v_o = fe_cmd_yumi_i & is_redirect_op;
  assign attaboy_v_o  = fe_cmd_yumi_i & is_attaboy_op;

  // The opcode picks which layout of the operand word is live
  always_comb
  begin
    if (is_redirect_op)
    begin
      metadata_o = fe_cmd_i.operands.pc_redirect_operands.branch_metadata;
    end
    else
    begin
      metadata_o = fe_cmd_i.operands.attaboy.branch_metadata;   // Also the don't-care case
    end
  end

  assign vaddr_o = fe_cmd_i.vaddr;

endmodule

// File: logic/bp_prof_pkg.sv
package bp_prof_pkg;

  localparam int VADDR_WIDTH     = 39;
  localparam int STAT_WIDTH      = 32;
  localparam int HISTO_ENTRIES   = 8;
  localparam int HISTO_IDX_WIDTH = 3;
  localparam int HISTO_CNT_WIDTH = 16;

  typedef enum logic [2:0]
  {
    e_op_state_reset    = 3'd0
    , e_op_pc_redirection = 3'd1
    , e_op_attaboy        = 3'd2
    , e_op_icache_fence   = 3'd3
    , e_op_itlb_fill      = 3'd4
  } bp_fe_cmd_opcode_e;

  // Branch class and prediction source as forwarded by the front end
  typedef struct packed
  {
    logic       is_br;
    logic       is_jal;
    logic       is_jalr;
    logic       src_btb;   // Target came from the BTB
    logic       src_ret;   // Target came from the return stack
    logic       bht_taken;
    logic [1:0] spare;
  } bp_branch_metadata_s;

  typedef struct packed
  {
    logic [1:0]          redirect_reason;
    logic [1:0]          misprediction_kind;
    bp_branch_metadata_s branch_metadata;
  } bp_fe_cmd_pc_redirect_operands_s;

  typedef struct packed
  {
    bp_branch_metadata_s branch_metadata;
    logic [3:0]          target_hint;   // Not used by the profiler
  } bp_fe_cmd_attaboy_s;

  // The metadata sits low in a redirect and high in an attaboy
  typedef union packed
  {
    bp_fe_cmd_pc_redirect_operands_s pc_redirect_operands;
    bp_fe_cmd_attaboy_s              attaboy;
  } bp_fe_cmd_operands_u;

  typedef struct packed
  {
    bp_fe_cmd_opcode_e        opcode;
    logic [VADDR_WIDTH-1:0]   vaddr;
    bp_fe_cmd_operands_u      operands;
  } bp_fe_cmd_s;

  typedef struct packed
  {
    logic [STAT_WIDTH-1:0] instr_cnt;
    logic [STAT_WIDTH-1:0] attaboy_cnt;
    logic [STAT_WIDTH-1:0] redirect_cnt;
    logic [STAT_WIDTH-1:0] br_cnt;
    logic [STAT_WIDTH-1:0] jal_cnt;
    logic [STAT_WIDTH-1:0] jalr_cnt;
    logic [STAT_WIDTH-1:0] btb_hit_cnt;
    logic [STAT_WIDTH-1:0] ras_hit_cnt;
    logic [STAT_WIDTH-1:0] bht_hit_cnt;
  } bp_branch_stats_s;

  typedef struct packed
  {
    logic                       valid;
    logic [VADDR_WIDTH-1:0]     vaddr;
    logic [HISTO_CNT_WIDTH-1:0] occ_cnt;
    logic [HISTO_CNT_WIDTH-1:0] miss_cnt;
  } bp_histo_entry_s;

  // Plain wrapping add of a one-bit strobe
  function automatic logic [STAT_WIDTH-1:0] stat_inc
    (input logic [STAT_WIDTH-1:0] cnt
     , input logic v
     );
    return cnt + STAT_WIDTH'(v);
  endfunction

  // Table counts stick at all ones
  function automatic logic [HISTO_CNT_WIDTH-1:0] cnt_sat_inc
    (input logic [HISTO_CNT_WIDTH-1:0] cnt
     , input logic v
     );
    return (v && (cnt != '1)) ? cnt + HISTO_CNT_WIDTH'(1) : cnt;
  endfunction

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f sim.f \
  --top-module bp_branch_profiler_tb \
  -o bp_branch_profiler_sim

./obj_dir/bp_branch_profiler_sim

// File: sim.f
logic/bp_prof_pkg.sv
logic/bp_fe_cmd_decoder.sv
logic/bp_branch_counters.sv
logic/bp_branch_histo_table.sv
logic/bp_branch_profiler.sv
verif/bp_branch_profiler_tb.sv

// File: verif/bp_branch_profiler_tb.sv
module bp_branch_profiler_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 2;
  localparam int NUM_RANDOM   = 40;

  localparam bp_prof_pkg::bp_fe_cmd_opcode_e OP_ATT   = bp_prof_pkg::e_op_attaboy;
  localparam bp_prof_pkg::bp_fe_cmd_opcode_e OP_RED   = bp_prof_pkg::e_op_pc_redirection;
  localparam bp_prof_pkg::bp_fe_cmd_opcode_e OP_FENCE = bp_prof_pkg::e_op_icache_fence;
  localparam bp_prof_pkg::bp_fe_cmd_opcode_e OP_ITLB  = bp_prof_pkg::e_op_itlb_fill;
  localparam bp_prof_pkg::bp_fe_cmd_opcode_e OP_RESET = bp_prof_pkg::e_op_state_reset;

  typedef struct packed
  {
    bp_prof_pkg::bp_fe_cmd_opcode_e        opcode;
    logic [bp_prof_pkg::VADDR_WIDTH-1:0]   vaddr;
    bp_prof_pkg::bp_branch_metadata_s      metadata;
    logic                                  redirect_layout;
    logic                                  yumi;
    logic                                  commit;
    logic                                  finish;
  } stim_row_s;

  logic                                      clk_i;
  logic                                      reset_i;
  bp_prof_pkg::bp_fe_cmd_s                   fe_cmd_i;
  logic                                      fe_cmd_yumi_i;
  logic                                      commit_v_i;
  logic                                      program_finish_i;
  logic [bp_prof_pkg::HISTO_IDX_WIDTH-1:0]   histo_idx_i;
  bp_prof_pkg::bp_branch_stats_s             stats_o;
  bp_prof_pkg::bp_histo_entry_s              histo_entry_o;
  logic [bp_prof_pkg::STAT_WIDTH-1:0]        histo_overflow_o;
  logic                                      report_v_o;

  stim_row_s stim_q [$];
  int        seed = 32'h3771;
  int        watchdog_ns = 0;

  bp_prof_pkg::bp_branch_stats_s      exp_stats;
  bp_prof_pkg::bp_histo_entry_s       exp_table [bp_prof_pkg::HISTO_ENTRIES];
  logic [bp_prof_pkg::STAT_WIDTH-1:0] exp_overflow;
  logic                               exp_report;
  logic                               finish_prev;

  bp_branch_profiler bp_branch_profiler_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fe_cmd_i(fe_cmd_i)
     ,.fe_cmd_yumi_i(fe_cmd_yumi_i)
     ,.commit_v_i(commit_v_i)
     ,.program_finish_i(program_finish_i)
     ,.histo_idx_i(histo_idx_i)
     ,.stats_o(stats_o)
     ,.histo_entry_o(histo_entry_o)
     ,.histo_overflow_o(histo_overflow_o)
     ,.report_v_o(report_v_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Twelve branch addresses with bit 38 set so the whole compare is exercised
  function automatic logic [bp_prof_pkg::VADDR_WIDTH-1:0] addr_of(input int k);
    return bp_prof_pkg::VADDR_WIDTH'(64'h40_0000_1000 + 64'(k) * 64'h28);
  endfunction

  task automatic add_row(input bp_prof_pkg::bp_fe_cmd_opcode_e op, input int addr_k,
                         input logic [7:0] md, input logic yumi, input logic commit,
                         input logic finish);
    stim_row_s row;
    row.opcode          = op;
    row.vaddr           = addr_of(addr_k);
    row.metadata        = md;
    row.redirect_layout = (op == OP_RED);
    row.yumi            = yumi;
    row.commit          = commit;
    row.finish          = finish;
    stim_q.push_back(row);
  endtask

  task automatic build_stimulus();
    logic [31:0] rnd;
    bp_prof_pkg::bp_fe_cmd_opcode_e op;
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b0, 1'b0);
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b1, 1'b0);   // Commit alone
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b1, 1'b0);
    add_row(OP_ATT, 0, 8'b1001_1100, 1'b1, 1'b0, 1'b0);
    add_row(OP_RED, 0, 8'b1001_1000, 1'b1, 1'b1, 1'b0);
    add_row(OP_ATT, 0, 8'b0101_0000, 1'b1, 1'b0, 1'b0);
    add_row(OP_ATT, 1, 8'hff, 1'b0, 1'b0, 1'b0);   // Offered but not taken
    add_row(OP_FENCE, 1, 8'hff, 1'b1, 1'b0, 1'b0);
    add_row(OP_ITLB, 2, 8'hff, 1'b1, 1'b1, 1'b0);
    add_row(OP_RESET, 3, 8'hff, 1'b1, 1'b0, 1'b0);
    add_row(OP_RED, 1, 8'b0010_1000, 1'b1, 1'b0, 1'b0);
    add_row(OP_ATT, 2, 8'b0010_1000, 1'b1, 1'b1, 1'b0);
    add_row(OP_RED, 1, 8'b1000_0100, 1'b1, 1'b0, 1'b0);
    for (int k = 3; k < 8; k++)
    begin
      add_row(OP_ATT, k, 8'b1001_0000, 1'b1, 1'b0, 1'b0);
    end
    add_row(OP_RED, 8, 8'b1000_0000, 1'b1, 1'b0, 1'b0);   // Table is full from here on
    add_row(OP_ATT, 9, 8'b0100_1000, 1'b1, 1'b0, 1'b0);
    add_row(OP_ATT, 5, 8'b1001_0100, 1'b1, 1'b0, 1'b0);
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b0, 1'b1);
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b0, 1'b1);
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b0, 1'b1);
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b0, 1'b0);
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b0, 1'b1);
    add_row(OP_ATT, 0, 8'h00, 1'b0, 1'b0, 1'b0);
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      rnd = $random(seed);
      case (rnd[2:0])
        3'd0, 3'd1, 3'd2: op = OP_ATT;
        3'd3, 3'd4, 3'd5: op = OP_RED;
        3'd6:             op = OP_FENCE;
        default:          op = OP_ITLB;
      endcase
      add_row(op, int'(rnd[15:12]) % 12, rnd[10:3], rnd[16] | rnd[17], rnd[18],
              rnd[20] & rnd[21]);
    end
  endtask

  // Filler bits are inverted copies of the overlapping metadata, so the wrong layout
  // always flips a counted bit
  task automatic drive_row(input stim_row_s row);
    fe_cmd_i.opcode = row.opcode;
    fe_cmd_i.vaddr  = row.vaddr;
    if (row.redirect_layout)
    begin
      fe_cmd_i.operands.pc_redirect_operands.redirect_reason    = ~row.metadata[7:6];
      fe_cmd_i.operands.pc_redirect_operands.misprediction_kind = ~row.metadata[5:4];
      fe_cmd_i.operands.pc_redirect_operands.branch_metadata    = row.metadata;
    end
    else
    begin
      fe_cmd_i.operands.attaboy.branch_metadata = row.metadata;
      fe_cmd_i.operands.attaboy.target_hint     = ~row.metadata[3:0];
    end
    fe_cmd_yumi_i    = row.yumi;
    commit_v_i       = row.commit;
    program_finish_i = row.finish;
  endtask

  task automatic model_reset();
    exp_stats = '0;
    for (int i = 0; i < bp_prof_pkg::HISTO_ENTRIES; i++)
    begin
      exp_table[i] = '0;
    end
    exp_overflow = '0;
    exp_report   = 1'b0;
    finish_prev  = 1'b0;
  endtask

  task automatic model_step(input stim_row_s row);
    logic att;
    logic red;
    int   hit_row;
    int   free_row;
    att = row.yumi && (row.opcode == OP_ATT);
    red = row.yumi && (row.opcode == OP_RED);
    if (row.commit) exp_stats.instr_cnt += 32'd1;
    if (att)
    begin
      exp_stats.attaboy_cnt += 32'd1;
      if (row.metadata.src_btb) exp_stats.btb_hit_cnt += 32'd1;
      if (row.metadata.src_ret) exp_stats.ras_hit_cnt += 32'd1;
      if (row.metadata.is_br) exp_stats.bht_hit_cnt += 32'd1;
    end
    if (red) exp_stats.redirect_cnt += 32'd1;
    if (att || red)
    begin
      if (row.metadata.is_br) exp_stats.br_cnt += 32'd1;
      if (row.metadata.is_jal) exp_stats.jal_cnt += 32'd1;
      if (row.metadata.is_jalr) exp_stats.jalr_cnt += 32'd1;
      hit_row  = -1;
      free_row = -1;
      for (int i = 0; i < bp_prof_pkg::HISTO_ENTRIES; i++)
      begin
        if (hit_row < 0 && exp_table[i].valid && exp_table[i].vaddr == row.vaddr) hit_row = i;
        if (free_row < 0 && !exp_table[i].valid) free_row = i;
      end
      if (hit_row >= 0)
      begin
        if (exp_table[hit_row].occ_cnt != '1) exp_table[hit_row].occ_cnt += 16'd1;
        if (red && exp_table[hit_row].miss_cnt != '1) exp_table[hit_row].miss_cnt += 16'd1;
      end
      else if (free_row >= 0)
      begin
        exp_table[free_row].valid    = 1'b1;
        exp_table[free_row].vaddr    = row.vaddr;
        exp_table[free_row].occ_cnt  = 16'd1;
        exp_table[free_row].miss_cnt = red ? 16'd1 : 16'd0;
      end
      else
      begin
        exp_overflow += 32'd1;
      end
    end
    exp_report  = row.finish && !finish_prev;   // Pulse shows one cycle after the edge
    finish_prev = row.finish;
  endtask

  task automatic fail_value(input string name, input string exp_s, input string act_s);
    $display("Fail at %0.3f ns: %s expected %s, got %s", $realtime, name, exp_s, act_s);
    $display("Result: FAILED");
    $fatal(1, "Mismatch on %s", name);
  endtask

  task automatic check_stats(input bp_prof_pkg::bp_branch_stats_s exp_v,
                             input bp_prof_pkg::bp_branch_stats_s act_v);
    if (act_v !== exp_v) fail_value("stats_o", $sformatf("%h", exp_v), $sformatf("%h", act_v));
  endtask

  task automatic check_entry(input int idx, input bp_prof_pkg::bp_histo_entry_s exp_v,
                             input bp_prof_pkg::bp_histo_entry_s act_v);
    if (act_v !== exp_v)
    begin
      fail_value($sformatf("histo_entry_o[%0d]", idx), $sformatf("%h", exp_v),
                 $sformatf("%h", act_v));
    end
  endtask

  task automatic check_bit(input string name, input logic [bp_prof_pkg::STAT_WIDTH-1:0] exp_v,
                           input logic [bp_prof_pkg::STAT_WIDTH-1:0] act_v);
    if (act_v !== exp_v) fail_value(name, $sformatf("%0d", exp_v), $sformatf("%0d", act_v));
  endtask

  // Registered outputs are stable here, the read port is swept row by row
  task automatic check_outputs();
    check_stats(exp_stats, stats_o);
    check_bit("histo_overflow_o", exp_overflow, histo_overflow_o);
    check_bit("report_v_o", 32'(exp_report), 32'(report_v_o));
    for (int i = 0; i < bp_prof_pkg::HISTO_ENTRIES; i++)
    begin
      histo_idx_i = bp_prof_pkg::HISTO_IDX_WIDTH'(i);
      #0.1;
      check_entry(i, exp_table[i], histo_entry_o);
    end
  endtask

  initial
  begin
    reset_i          = 1'b1;
    fe_cmd_i         = '0;
    fe_cmd_yumi_i    = 1'b0;
    commit_v_i       = 1'b0;
    program_finish_i = 1'b0;
    histo_idx_i      = '0;
    build_stimulus();
    model_reset();
    watchdog_ns = (stim_q.size() + RESET_CYCLES + 10) * CLK_PERIOD;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    foreach (stim_q[k])
    begin
      drive_row(stim_q[k]);
      check_outputs();
      model_step(stim_q[k]);
      @(negedge clk_i);
    end
    check_outputs();
    $display("Result: PASSED");
    $finish;
  end

  initial
  begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("Timeout: the stimulus rows did not complete within %0d ns", watchdog_ns);
    $display("Result: FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule
